// File: src.f
common/bus_bridge_pkg.sv
bridge/bridge_ctrl.sv
bridge/rsp_timer.sv
rtl/reg_target.sv
rtl/bridge_top.sv
tb/bridge_properties.sv
tb/bridge_checker.sv
tb/bridge_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= bridge_tb
FILELIST  ?= src.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

# The log decides pass or fail, whatever the simulator exit code
run: compile
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: tb/bridge_tb.sv
/*
 * Bridge testbench
 * Clock, reset, stimulus table checked against a shadow memory,
 * driver loop and watchdog around the bus request bridge
 */

module bridge_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import bus_bridge_pkg::*;

	localparam int TIMEOUT_CYCLES  = 32;
	localparam int WAIT_CYCLES     = 3;
	localparam int MEM_WORDS       = 16;
	localparam int NUM_TESTS       = 12;
	localparam int RESET_CYCLES    = 5;
	localparam int LONG_STALL      = 2 * TIMEOUT_CYCLES;
	localparam int WATCHDOG_CYCLES =
		RESET_CYCLES + NUM_TESTS * (2 * TIMEOUT_CYCLES + WAIT_CYCLES + 10);
	localparam logic [31:0] SEED   = 32'h7418_c3f6;

	logic              rvx_port_04;
	logic              rvx_port_12;
	logic              req;
	logic              write;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;
	logic              stall;
	logic              busy;
	logic              done;
	logic [DATA_W-1:0] rdata;
	rsp_status_t       status;

	// Expected result of the request in flight
	logic [DATA_W-1:0] exp_rdata;
	rsp_status_t       exp_status;
	int                test_idx;
	int                err_count;
	int                done_count;

	// ********************************************************
	// Stimulus table
	// ********************************************************

	logic              t_write     [NUM_TESTS];
	logic [ADDR_W-1:0] t_addr      [NUM_TESTS];
	logic [DATA_W-1:0] t_wdata     [NUM_TESTS];
	int                t_stall     [NUM_TESTS];
	logic [DATA_W-1:0] t_exp_rdata [NUM_TESTS];
	rsp_status_t       t_exp_status[NUM_TESTS];

	// Reference copy of the target memory
	logic [DATA_W-1:0] shadow [MEM_WORDS];

	bridge_top #(
		.TIMEOUT_CYCLES (TIMEOUT_CYCLES),
		.WAIT_CYCLES    (WAIT_CYCLES),
		.MEM_WORDS      (MEM_WORDS)
	) dut (
		.rvx_port_04 (rvx_port_04),
		.rvx_port_12 (rvx_port_12),
		.req         (req),
		.write       (write),
		.addr        (addr),
		.wdata       (wdata),
		.busy        (busy),
		.done        (done),
		.rdata       (rdata),
		.status      (status),
		.stall       (stall)
	);

	bridge_checker u_checker (
		.rvx_port_04 (rvx_port_04),
		.rvx_port_12 (rvx_port_12),
		.req         (req),
		.busy        (busy),
		.done        (done),
		.rdata       (rdata),
		.status      (status),
		.exp_rdata   (exp_rdata),
		.exp_status  (exp_status),
		.test_idx    (test_idx),
		.err_count   (err_count),
		.done_count  (done_count)
	);

	// 20 ns clock
	initial
	begin
		rvx_port_04 = 1'b0;
	end

	always #10 rvx_port_04 = ~rvx_port_04;

	// One table row with random write data
	task automatic set_entry(input int i, input logic w, input logic [ADDR_W-1:0] a,
		input int s);
	begin
		t_write[i] = w;
		t_addr[i]  = a;
		t_wdata[i] = $urandom;
		t_stall[i] = s;
	end
	endtask

	task automatic build_table();
	begin
		// Write then read back a mapped word
		set_entry(0, 1'b1, 16'h0003, 0);
		set_entry(1, 1'b0, 16'h0003, 0);
		// Never written since reset
		set_entry(2, 1'b0, 16'h0007, 0);
		// Unmapped write whose low bits alias word 4
		set_entry(3, 1'b1, 16'h0014, 0);
		set_entry(4, 1'b0, 16'h0004, 0);
		set_entry(5, 1'b0, 16'h0100, 0);
		// Short stalls only delay the access
		set_entry(6, 1'b1, 16'h0009, 5);
		set_entry(7, 1'b0, 16'h0009, 3);
		// Stall past the timeout aborts the write
		set_entry(8, 1'b1, 16'h0005, LONG_STALL);
		set_entry(9, 1'b0, 16'h0005, 0);
		set_entry(10, 1'b1, 16'h000f, 0);
		set_entry(11, 1'b0, 16'h000f, 2);
	end
	endtask

	// Expected results from the access rules applied to the shadow memory
	task automatic predict_table();
	begin
		for (int m = 0; m < MEM_WORDS; m++)
			shadow[m] = '0;
		for (int i = 0; i < NUM_TESTS; i++)
		begin
			if (t_stall[i] >= TIMEOUT_CYCLES)
			begin
				t_exp_rdata[i]  = '0;
				t_exp_status[i] = ERR_TIMEOUT;
			end
			else if (int'(t_addr[i]) >= MEM_WORDS)
			begin
				t_exp_rdata[i]  = '0;
				t_exp_status[i] = ERR_UNMAPPED;
			end
			else if (t_write[i])
			begin
				// Write completions carry zero data
				shadow[int'(t_addr[i])] = t_wdata[i];
				t_exp_rdata[i]  = '0;
				t_exp_status[i] = OKAY;
			end
			else
			begin
				t_exp_rdata[i]  = shadow[int'(t_addr[i])];
				t_exp_status[i] = OKAY;
			end
		end
	end
	endtask

	// ********************************************************
	// Driver
	// ********************************************************

	task automatic run_entry(input int i);
	begin
		@(posedge rvx_port_04);
		test_idx   <= i;
		exp_rdata  <= t_exp_rdata[i];
		exp_status <= t_exp_status[i];
		req        <= 1'b1;
		write      <= t_write[i];
		addr       <= t_addr[i];
		wdata      <= t_wdata[i];
		stall      <= (t_stall[i] != 0);
		fork
			begin
				repeat (t_stall[i]) @(posedge rvx_port_04);
				stall <= 1'b0;
			end
			begin
				// Bridge is idle here, so req is taken on the next edge
				@(posedge rvx_port_04);
				req <= 1'b0;
				// Stray request with other fields while busy, to be ignored
				@(posedge rvx_port_04);
				req   <= 1'b1;
				write <= !t_write[i];
				addr  <= ~t_addr[i];
				wdata <= ~t_wdata[i];
				@(posedge rvx_port_04);
				req <= 1'b0;
				do
					@(negedge rvx_port_04);
				while (!done);
			end
		join
	end
	endtask

	initial
	begin
		void'($urandom(SEED));
		rvx_port_12 = 1'b0;
		req         = 1'b0;
		write       = 1'b0;
		addr        = '0;
		wdata       = '0;
		stall       = 1'b0;
		test_idx    = 0;
		exp_rdata   = '0;
		exp_status  = OKAY;
		build_table();
		predict_table();
		repeat (RESET_CYCLES) @(posedge rvx_port_04);
		rvx_port_12 <= 1'b1;
		for (int i = 0; i < NUM_TESTS; i++)
			run_entry(i);
		// Room for a stray second done
		repeat (4) @(posedge rvx_port_04);
		if (done_count != NUM_TESTS)
			$display("Only %0d of %0d requests completed", done_count, NUM_TESTS);
		$display("Tests: %0d, completions: %0d, errors: %0d", NUM_TESTS, done_count,
			err_count);
		if (err_count == 0 && done_count == NUM_TESTS)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// Watchdog sized for every entry hitting the long stall
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge rvx_port_04);
		$display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("Checks failed");
		$finish;
	end

endmodule

// File: tb/bridge_checker.sv
/*
 * Bridge completion checker
 * Tracks requests at the host port, compares each completion
 * with the expected values and counts the errors
 */

module bridge_checker (
	input  logic                              rvx_port_04,
	input  logic                              rvx_port_12,
	input  logic                              req,
	input  logic                              busy,
	input  logic                              done,
	input  logic [bus_bridge_pkg::DATA_W-1:0] rdata,
	input  bus_bridge_pkg::rsp_status_t       status,
	input  logic [bus_bridge_pkg::DATA_W-1:0] exp_rdata,
	input  bus_bridge_pkg::rsp_status_t       exp_status,
	input  int                                test_idx,
	output int                                err_count,
	output int                                done_count
);

	timeunit 1ns;
	timeprecision 100ps;

	import bus_bridge_pkg::*;

	int   errors    = 0;
	int   completed = 0;
	logic in_flight = 1'b0;
	// Set after the completion until the next acceptance
	logic answered  = 1'b0;

	assign err_count  = errors;
	assign done_count = completed;

	task automatic check_result();
		bit ok = 1'b1;
	begin
		completed++;
		if (rdata !== exp_rdata)
		begin
			$display("[ERROR] test %0d rdata: got %h expected %h", test_idx, rdata, exp_rdata);
			ok = 1'b0;
		end
		if (status !== exp_status)
		begin
			$display("[ERROR] test %0d status: got %h expected %h", test_idx, status,
				exp_status);
			ok = 1'b0;
		end
		if (ok)
			$display("test %0d passed: rdata %h status %s", test_idx, rdata, status.name());
		else
			errors++;
	end
	endtask

	// Host signals change on rising edges, so the falling edge sees them settled
	always @(negedge rvx_port_04)
	begin
		if (!rvx_port_12)
		begin
			in_flight = 1'b0;
			answered  = 1'b0;
		end
		else
		begin
			if (done)
			begin
				if (in_flight)
				begin
					check_result();
					in_flight = 1'b0;
					answered  = 1'b1;
				end
				else if (answered)
				begin
					$display("test %0d: a second done came for the same request", test_idx);
					errors++;
				end
				else
				begin
					$display("test %0d: done came without a request", test_idx);
					errors++;
				end
			end
			else if (in_flight && !busy)
			begin
				$display("test %0d: busy went low before done", test_idx);
				errors++;
				in_flight = 1'b0;
			end
			// Taken by the bridge on the coming rising edge
			if (req && !busy)
			begin
				in_flight = 1'b1;
				answered  = 1'b0;
			end
		end
	end

endmodule

// File: tb/bridge_properties.sv
/*
 * Bridge controller assertions
 * Command beat stability, single-cycle done and no new
 * request taken while one is outstanding
 */

module bridge_properties (
	input logic                              rvx_port_04,
	input logic                              rvx_port_12,
	input logic                              req,
	input logic                              done,
	input logic                              cmd_valid,
	input logic                              cmd_ready,
	input logic                              cmd_write,
	input logic [bus_bridge_pkg::ADDR_W-1:0] cmd_addr,
	input logic [bus_bridge_pkg::DATA_W-1:0] cmd_wdata,
	input logic                              expired,
	input bus_bridge_pkg::bridge_state_t     state
);

	timeunit 1ns;
	timeprecision 100ps;

	import bus_bridge_pkg::*;

	// A pending beat stays put until taken, or is withdrawn on expiry
	cmd_hold: assert property (@(posedge rvx_port_04) disable iff (!rvx_port_12)
		cmd_valid && !cmd_ready |=> expired ||
		(cmd_valid && $stable(cmd_write) && $stable(cmd_addr) && $stable(cmd_wdata)))
		else $error("cmd_valid dropped or its fields changed before the transfer");

	done_pulse: assert property (@(posedge rvx_port_04) disable iff (!rvx_port_12)
		done |=> !done)
		else $error("done stayed high for more than one cycle");

	// A host request during an outstanding one leaves the latched fields alone
	no_accept_busy: assert property (@(posedge rvx_port_04) disable iff (!rvx_port_12)
		state != IDLE && req |=>
		$stable(cmd_write) && $stable(cmd_addr) && $stable(cmd_wdata))
		else $error("request accepted while the bridge was busy");

endmodule

bind bridge_ctrl bridge_properties u_props (
	.rvx_port_04 (rvx_port_04),
	.rvx_port_12 (rvx_port_12),
	.req         (req),
	.done        (done),
	.cmd_valid   (cmd_valid),
	.cmd_ready   (cmd_ready),
	.cmd_write   (cmd_write),
	.cmd_addr    (cmd_addr),
	.cmd_wdata   (cmd_wdata),
	.expired     (expired),
	.state       (state)
);

// File: rtl/bridge_top.sv
/*
 * Bus request bridge top level
 * Host port to command/response bus bridge with a response
 * timer and a register memory target behind it
 */

module bridge_top #(
	parameter int TIMEOUT_CYCLES = 32,
	parameter int WAIT_CYCLES    = 3,
	parameter int MEM_WORDS      = 16
) (
	input  logic                                rvx_port_04,
	input  logic                                rvx_port_12,

	// Host port
	input  logic                                req,
	input  logic                                write,
	input  logic [bus_bridge_pkg::ADDR_W-1:0]   addr,
	input  logic [bus_bridge_pkg::DATA_W-1:0]   wdata,
	output logic                                busy,
	output logic                                done,
	output logic [bus_bridge_pkg::DATA_W-1:0]   rdata,
	output bus_bridge_pkg::rsp_status_t         status,

	// Target hold-off
	input  logic                                stall
);

	import bus_bridge_pkg::*;

	// ********************************************************
	// Internal channels
	// ********************************************************

	// Command channel
	logic              cmd_valid;
	logic              cmd_ready;
	logic              cmd_write;
	logic [ADDR_W-1:0] cmd_addr;
	logic [DATA_W-1:0] cmd_wdata;

	// Response channel
	logic              rsp_valid;
	logic              rsp_ready;
	logic [DATA_W-1:0] rsp_rdata;
	rsp_status_t       rsp_status;

	// Timer link
	logic              run;
	logic              expired;

	// Request FSM
	bridge_ctrl #(
		.TIMEOUT_CYCLES (TIMEOUT_CYCLES)
	) u_ctrl (
		.rvx_port_04 (rvx_port_04),
		.rvx_port_12 (rvx_port_12),
		.req         (req),
		.write       (write),
		.addr        (addr),
		.wdata       (wdata),
		.busy        (busy),
		.done        (done),
		.rdata       (rdata),
		.status      (status),
		.cmd_valid   (cmd_valid),
		.cmd_ready   (cmd_ready),
		.cmd_write   (cmd_write),
		.cmd_addr    (cmd_addr),
		.cmd_wdata   (cmd_wdata),
		.rsp_valid   (rsp_valid),
		.rsp_ready   (rsp_ready),
		.rsp_rdata   (rsp_rdata),
		.rsp_status  (rsp_status),
		.run         (run),
		.expired     (expired)
	);

	// Outstanding request timer
	rsp_timer #(
		.TIMEOUT_CYCLES (TIMEOUT_CYCLES)
	) u_timer (
		.rvx_port_04 (rvx_port_04),
		.rvx_port_12 (rvx_port_12),
		.run         (run),
		.expired     (expired)
	);

	// Register memory target
	reg_target #(
		.WAIT_CYCLES (WAIT_CYCLES),
		.MEM_WORDS   (MEM_WORDS)
	) u_target (
		.rvx_port_04 (rvx_port_04),
		.rvx_port_12 (rvx_port_12),
		.stall       (stall),
		.cmd_valid   (cmd_valid),
		.cmd_ready   (cmd_ready),
		.cmd_write   (cmd_write),
		.cmd_addr    (cmd_addr),
		.cmd_wdata   (cmd_wdata),
		.rsp_valid   (rsp_valid),
		.rsp_ready   (rsp_ready),
		.rsp_rdata   (rsp_rdata),
		.rsp_status  (rsp_status)
	);

endmodule

// File: rtl/reg_target.sv
/*
 * Register memory bus target
 * Single-beat command/response target with a fixed response
 * delay, unmapped address reporting and an external stall input
 */

module reg_target #(
	parameter int WAIT_CYCLES = 3,
	parameter int MEM_WORDS   = 16
) (
	input  logic                                rvx_port_04,
	input  logic                                rvx_port_12,

	// Holds off new commands while high
	input  logic                                stall,

	// Command channel
	input  logic                                cmd_valid,
	output logic                                cmd_ready,
	input  logic                                cmd_write,
	input  logic [bus_bridge_pkg::ADDR_W-1:0]   cmd_addr,
	input  logic [bus_bridge_pkg::DATA_W-1:0]   cmd_wdata,

	// Response channel
	output logic                                rsp_valid,
	input  logic                                rsp_ready,
	output logic [bus_bridge_pkg::DATA_W-1:0]   rsp_rdata,
	output bus_bridge_pkg::rsp_status_t         rsp_status
);

	import bus_bridge_pkg::*;

	localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
	localparam int CNT_W = (WAIT_CYCLES > 1) ? $clog2(WAIT_CYCLES + 1) : 1;

	logic [DATA_W-1:0] mem [MEM_WORDS];
	logic              armed;
	logic              pending;
	logic [CNT_W-1:0]  wait_cnt;
	logic              accept;
	logic              rsp_fire;
	logic              mapped;
	logic [IDX_W-1:0]  idx;

	// ********************************************************
	// Command decode
	// ********************************************************

	// Anything at or past MEM_WORDS is unmapped
	assign mapped = (int'(cmd_addr) < MEM_WORDS);
	assign idx    = cmd_addr[IDX_W-1:0];

	// armed keeps ready low through reset and the first edge after it
	assign cmd_ready = armed && !pending && !stall;
	assign accept    = cmd_valid && cmd_ready;
	assign rsp_fire  = rsp_valid && rsp_ready;

	// ********************************************************
	// Access sequencing
	// ********************************************************

	// One access at a time
	// the response is raised WAIT_CYCLES cycles after acceptance
	always_ff @(posedge rvx_port_04 or negedge rvx_port_12)
	begin
		if (!rvx_port_12)
		begin
			armed     <= 1'b0;
			pending   <= 1'b0;
			wait_cnt  <= '0;
			rsp_valid <= 1'b0;
		end
		else
		begin
			armed <= 1'b1;
			if (accept)
			begin
				pending <= 1'b1;
				if (WAIT_CYCLES == 0)
					rsp_valid <= 1'b1;
				else
					wait_cnt <= CNT_W'(WAIT_CYCLES);
			end
			else if (rsp_fire)
			begin
				// Free for the next command
				pending   <= 1'b0;
				rsp_valid <= 1'b0;
			end
			else if (wait_cnt != '0)
			begin
				wait_cnt <= wait_cnt - 1'b1;
				// Last wait cycle
				if (wait_cnt == CNT_W'(1))
					rsp_valid <= 1'b1;
			end
		end
	end

	// Register memory, cleared by reset
	// unmapped writes are dropped
	always_ff @(posedge rvx_port_04 or negedge rvx_port_12)
	begin
		if (!rvx_port_12)
		begin
			for (int i = 0; i < MEM_WORDS; i++)
				mem[i] <= '0;
		end
		else if (accept && cmd_write && mapped)
		begin
			mem[idx] <= cmd_wdata;
		end
	end

	// Response payload captured at acceptance and held while rsp_valid waits
	always_ff @(posedge rvx_port_04)
	begin
		if (accept)
		begin
			if (mapped)
			begin
				rsp_status <= OKAY;
				// Writes return zero data
				rsp_rdata  <= cmd_write ? '0 : mem[idx];
			end
			else
			begin
				rsp_status <= ERR_UNMAPPED;
				rsp_rdata  <= '0;
			end
		end
	end

endmodule

// File: bridge/rsp_timer.sv
/*
 * Response timer
 * Counts cycles while a request is outstanding and flags
 * expiry once the count reaches the timeout limit
 */

module rsp_timer #(
	parameter int TIMEOUT_CYCLES = 32
) (
	input  logic rvx_port_04,
	input  logic rvx_port_12,
	input  logic run,
	output logic expired
);

	// Counter just wide enough to hold TIMEOUT_CYCLES-1
	localparam int CNT_W = (TIMEOUT_CYCLES > 2) ? $clog2(TIMEOUT_CYCLES) : 1;
	localparam logic [CNT_W-1:0] LIMIT = CNT_W'(TIMEOUT_CYCLES - 1);

	logic [CNT_W-1:0] count;

	// Saturating count, cleared whenever the bridge is idle
	always_ff @(posedge rvx_port_04 or negedge rvx_port_12)
	begin
		if (!rvx_port_12)
		begin
			count <= '0;
		end
		else if (!run)
		begin
			count <= '0;
		end
		else if (count != LIMIT)
		begin
			count <= count + 1'b1;
		end
	end

	// Level stays high until run drops
	assign expired = run && (count == LIMIT);

endmodule

// File: bridge/bridge_ctrl.sv
/*
 * Bridge controller
 * Accepts one host request at a time, issues a single command
 * beat and returns the response data and status, or a timeout
 */

module bridge_ctrl #(
	parameter int TIMEOUT_CYCLES = 32
) (
	input  logic                                rvx_port_04,
	input  logic                                rvx_port_12,

	// Host request side
	input  logic                                req,
	input  logic                                write,
	input  logic [bus_bridge_pkg::ADDR_W-1:0]   addr,
	input  logic [bus_bridge_pkg::DATA_W-1:0]   wdata,
	output logic                                busy,
	output logic                                done,
	output logic [bus_bridge_pkg::DATA_W-1:0]   rdata,
	output bus_bridge_pkg::rsp_status_t         status,

	// Command channel
	output logic                                cmd_valid,
	input  logic                                cmd_ready,
	output logic                                cmd_write,
	output logic [bus_bridge_pkg::ADDR_W-1:0]   cmd_addr,
	output logic [bus_bridge_pkg::DATA_W-1:0]   cmd_wdata,

	// Response channel
	input  logic                                rsp_valid,
	output logic                                rsp_ready,
	input  logic [bus_bridge_pkg::DATA_W-1:0]   rsp_rdata,
	input  bus_bridge_pkg::rsp_status_t         rsp_status,

	// Response timer
	output logic                                run,
	input  logic                                expired
);

	import bus_bridge_pkg::*;

	bridge_state_t state;
	logic          active;
	logic          accept;
	logic          cmd_fire;
	logic          rsp_fire;
	logic          abort;
	logic          finish;

	// ********************************************************
	// Handshake decode
	// ********************************************************

	// Request outstanding, command pending or response awaited
	assign active = (state == ISSUE) || (state == WAIT);

	// Host request taken only when idle
	assign busy   = (state != IDLE);
	assign accept = req && !busy;

	// A response always wins over expiry in the same cycle
	assign rsp_fire = rsp_valid && rsp_ready;
	assign abort    = active && expired && !rsp_fire;
	assign finish   = rsp_fire || abort;

	// Command withdrawn in the expiry cycle so an aborted beat is never delivered
	assign cmd_valid = (state == ISSUE) && !abort;
	assign cmd_fire  = cmd_valid && cmd_ready;

	// Ready for a response from the moment the command is presented
	assign rsp_ready = active;
	assign run       = active;

	// ********************************************************
	// FSM
	// ********************************************************

	always_ff @(posedge rvx_port_04 or negedge rvx_port_12)
	begin
		if (!rvx_port_12)
		begin
			state <= IDLE;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (accept)
						state <= ISSUE;
				end
				ISSUE:
				begin
					// Same-cycle response skips WAIT
					if (finish)
						state <= IDLE;
					else if (cmd_fire)
						state <= WAIT;
				end
				WAIT:
				begin
					if (finish)
						state <= IDLE;
				end
				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Request fields latched at acceptance and held as the command beat
	always_ff @(posedge rvx_port_04)
	begin
		if (accept)
		begin
			cmd_write <= write;
			cmd_addr  <= addr;
			cmd_wdata <= wdata;
		end
	end

	// ********************************************************
	// Completion
	// ********************************************************

	// One done pulse per request, result held until the next done
	always_ff @(posedge rvx_port_04 or negedge rvx_port_12)
	begin
		if (!rvx_port_12)
		begin
			done   <= 1'b0;
			rdata  <= '0;
			status <= OKAY;
		end
		else
		begin
			done <= finish;
			if (rsp_fire)
			begin
				rdata  <= rsp_rdata;
				status <= rsp_status;
			end
			else if (abort)
			begin
				// Timeout returns zero data
				rdata  <= '0;
				status <= ERR_TIMEOUT;
			end
		end
	end

endmodule

// File: common/bus_bridge_pkg.sv
/*
 * Bus bridge shared definitions
 * Address and data widths, response status codes and the
 * bridge FSM state encoding used across the subsystem
 */

package bus_bridge_pkg;

	// ********************************************************
	// Widths
	// ********************************************************

	// Word address width on host and command side
	localparam int ADDR_W = 16;

	// Data word width for write data and read data
	localparam int DATA_W = 32;

	// ********************************************************
	// Encodings
	// ********************************************************

	// Completion status returned with every response
	// OKAY for a normal access
	// ERR_UNMAPPED when the address falls outside the target memory
	// ERR_TIMEOUT when the bridge gave up waiting
	typedef enum logic [1:0]
	{
		OKAY         = 2'd0,
		ERR_UNMAPPED = 2'd1,
		ERR_TIMEOUT  = 2'd2
	} rsp_status_t;

	// Bridge FSM states
	// IDLE waits for a host request
	// ISSUE presents the command beat
	// WAIT holds until the response arrives
	typedef enum logic [1:0]
	{
		IDLE  = 2'd0,
		ISSUE = 2'd1,
		WAIT  = 2'd2
	} bridge_state_t;

endpackage
